//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

   localparam int data_width = 32;
   localparam int num_gprs = 8;

   // Credits held by the producer after reset
   localparam int instr_queue_depth = 4;

   typedef logic [2:0] gpr_id_t;

   typedef enum logic [3:0] {
      op_add  = 4'h0,
      op_sub  = 4'h1,
      op_and  = 4'h2,
      op_xor  = 4'h3,
      op_movi = 4'h4,
      op_ld   = 4'h5,
      op_st   = 4'h6,
      op_nop  = 4'hf
   } opcode_e;

   // Register form: dr = sr1 op sr2
   typedef struct packed {
      opcode_e     opcode;
      gpr_id_t     dr;
      gpr_id_t     sr1;
      gpr_id_t     sr2;
      logic [18:0] pad;
   } instr_rr_t;

   // Memory form: movi, ld and st with base plus displacement
   typedef struct packed {
      opcode_e            opcode;
      gpr_id_t            dr;
      gpr_id_t            base;
      logic signed [15:0] disp;
      logic [5:0]         pad;
   } instr_mem_t;

   // Opcode sits in bits 31:28 of both views
   typedef union packed {
      instr_rr_t  rr;
      instr_mem_t mem;
   } instr_u;

   typedef enum logic [1:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_xor
   } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

   localparam int dmem_words = 64;
   localparam int dmem_addr_width = 6;

   typedef logic [dmem_addr_width-1:0] dmem_addr_t;

   // Pipeline wins every conflict
   typedef enum logic {
      req_pipe,
      req_host
   } requester_e;

endpackage

`default_nettype wire

//--- verilog/dmem_if.sv
`default_nettype none

interface dmem_if;

   logic                             req;
   logic                             we;
   dmem_pkg::dmem_addr_t             addr;
   logic [isa_pkg::data_width-1:0]   wdata;
   logic                             gnt;
   // Valid the cycle after a read grant
   logic [isa_pkg::data_width-1:0]   rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface

`default_nettype wire

//--- verilog/instr_queue.sv
`default_nettype none

module instr_queue (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            push,
   input  isa_pkg::instr_u push_word,
   input  logic            pop,
   output isa_pkg::instr_u head,
   output logic            head_valid,
   output logic            credit
);

   isa_pkg::instr_u                                    fifo_q [isa_pkg::instr_queue_depth];
   logic [$clog2(isa_pkg::instr_queue_depth)-1:0]      wr_ptr;
   logic [$clog2(isa_pkg::instr_queue_depth)-1:0]      rd_ptr;
   logic [$clog2(isa_pkg::instr_queue_depth):0]        count;

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_q[wr_ptr] <= push_word;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One credit back per word taken by decode
         credit <= pop;
      end
   end

   assign head       = fifo_q[rd_ptr];
   assign head_valid = (count != '0);

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`default_nettype none

module register_file (
   input  logic                           clk,
   input  logic                           arst_n,
   input  isa_pkg::gpr_id_t               rd_addr_a,
   input  isa_pkg::gpr_id_t               rd_addr_b,
   output logic [isa_pkg::data_width-1:0] rd_data_a,
   output logic [isa_pkg::data_width-1:0] rd_data_b,
   input  logic                           wr_en,
   input  isa_pkg::gpr_id_t               wr_addr,
   input  logic [isa_pkg::data_width-1:0] wr_data
);

   logic [isa_pkg::data_width-1:0] gpr_q [isa_pkg::num_gprs];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < isa_pkg::num_gprs; i++) begin
            gpr_q[i] <= '0;
         end
      end else if (wr_en) begin
         gpr_q[wr_addr] <= wr_data;
      end
   end

   // No write bypass, decode stalls until the write has landed
   assign rd_data_a = gpr_q[rd_addr_a];
   assign rd_data_b = gpr_q[rd_addr_b];

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  isa_pkg::instr_u                head,
   input  logic                           head_valid,
   output logic                           pop,
   output isa_pkg::gpr_id_t               rd_addr_a,
   output isa_pkg::gpr_id_t               rd_addr_b,
   input  logic [isa_pkg::data_width-1:0] rd_data_a,
   input  logic [isa_pkg::data_width-1:0] rd_data_b,
   input  isa_pkg::gpr_id_t               ex_busy_dr,
   input  logic                           ex_writes,
   input  isa_pkg::gpr_id_t               me_busy_dr,
   input  logic                           me_writes,
   output logic                           de_valid,
   output isa_pkg::opcode_e               de_op,
   output isa_pkg::gpr_id_t               de_dr,
   output logic [isa_pkg::data_width-1:0] de_a,
   output logic [isa_pkg::data_width-1:0] de_b,
   output logic [15:0]                    de_disp
);

   isa_pkg::gpr_id_t dr;
   logic             use_a;
   logic             use_b;
   logic             de_writes;
   logic             hazard;

   // Pick the union view from the shared opcode field
   always_comb begin
      rd_addr_a = '0;
      rd_addr_b = '0;
      use_a     = 1'b0;
      use_b     = 1'b0;
      dr        = head.mem.dr;
      case (head.rr.opcode)
         isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_xor: begin
            dr        = head.rr.dr;
            rd_addr_a = head.rr.sr1;
            rd_addr_b = head.rr.sr2;
            use_a     = 1'b1;
            use_b     = 1'b1;
         end
         isa_pkg::op_ld: begin
            rd_addr_a = head.mem.base;
            use_a     = 1'b1;
         end
         // Store data comes from the dr register
         isa_pkg::op_st: begin
            rd_addr_a = head.mem.base;
            rd_addr_b = head.mem.dr;
            use_a     = 1'b1;
            use_b     = 1'b1;
         end
         default: ;
      endcase
   end

   assign de_writes = de_valid && (de_op != isa_pkg::op_st) && (de_op != isa_pkg::op_nop);

   // RAW check against all three writers in flight
   assign hazard =
      (use_a && de_writes && (rd_addr_a == de_dr)) ||
      (use_b && de_writes && (rd_addr_b == de_dr)) ||
      (use_a && ex_writes && (rd_addr_a == ex_busy_dr)) ||
      (use_b && ex_writes && (rd_addr_b == ex_busy_dr)) ||
      (use_a && me_writes && (rd_addr_a == me_busy_dr)) ||
      (use_b && me_writes && (rd_addr_b == me_busy_dr));

   // Bubble behind a load, it holds the memory stage for two cycles
   assign pop = head_valid && !hazard && !(de_valid && de_op == isa_pkg::op_ld);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de_valid <= 1'b0;
      end else begin
         de_valid <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         de_op   <= head.rr.opcode;
         de_dr   <= dr;
         de_a    <= rd_data_a;
         de_b    <= rd_data_b;
         de_disp <= head.mem.disp;
      end
   end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           de_valid,
   input  isa_pkg::opcode_e               de_op,
   input  isa_pkg::gpr_id_t               de_dr,
   input  logic [isa_pkg::data_width-1:0] de_a,
   input  logic [isa_pkg::data_width-1:0] de_b,
   input  logic [15:0]                    de_disp,
   output logic                           ex_valid,
   output isa_pkg::opcode_e               ex_op,
   output isa_pkg::gpr_id_t               ex_dr,
   output logic [isa_pkg::data_width-1:0] ex_result,
   output logic [isa_pkg::data_width-1:0] ex_store_data,
   output logic                           ex_writes
);

   isa_pkg::alu_op_e               alu_op;
   logic                           is_rr;
   logic [isa_pkg::data_width-1:0] disp_ext;
   logic [isa_pkg::data_width-1:0] op_a;
   logic [isa_pkg::data_width-1:0] op_b;
   logic [isa_pkg::data_width-1:0] result;

   assign is_rr = (de_op == isa_pkg::op_add) || (de_op == isa_pkg::op_sub) ||
                  (de_op == isa_pkg::op_and) || (de_op == isa_pkg::op_xor);

   assign disp_ext = {{(isa_pkg::data_width - 16){de_disp[15]}}, de_disp};

   // movi adds the displacement to zero, ld and st to the base
   assign op_a = (de_op == isa_pkg::op_movi) ? '0 : de_a;
   assign op_b = is_rr ? de_b : disp_ext;

   always_comb begin
      case (de_op)
         isa_pkg::op_sub: alu_op = isa_pkg::alu_sub;
         isa_pkg::op_and: alu_op = isa_pkg::alu_and;
         isa_pkg::op_xor: alu_op = isa_pkg::alu_xor;
         default:         alu_op = isa_pkg::alu_add;
      endcase
   end

   always_comb begin
      case (alu_op)
         isa_pkg::alu_sub: result = op_a - op_b;
         isa_pkg::alu_and: result = op_a & op_b;
         isa_pkg::alu_xor: result = op_a ^ op_b;
         default:          result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_valid  <= 1'b0;
         ex_writes <= 1'b0;
      end else begin
         ex_valid  <= de_valid;
         ex_writes <= de_valid && (de_op != isa_pkg::op_st) && (de_op != isa_pkg::op_nop);
      end
   end

   always_ff @(posedge clk) begin
      ex_op         <= de_op;
      ex_dr         <= de_dr;
      ex_result     <= result;
      ex_store_data <= de_b;
   end

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`default_nettype none

module memory_stage (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           ex_valid,
   input  isa_pkg::opcode_e               ex_op,
   input  isa_pkg::gpr_id_t               ex_dr,
   input  logic [isa_pkg::data_width-1:0] ex_result,
   input  logic [isa_pkg::data_width-1:0] ex_store_data,
   input  logic                           ex_writes,
   dmem_if.requester                      pipe_bus,
   output isa_pkg::gpr_id_t               me_busy_dr,
   output logic                           me_writes,
   output logic                           wb_valid,
   output isa_pkg::gpr_id_t               wb_dr,
   output logic [isa_pkg::data_width-1:0] wb_data
);

   logic             is_ld;
   logic             is_st;
   logic             pend_valid;
   isa_pkg::gpr_id_t pend_dr;

   assign is_ld = ex_valid && (ex_op == isa_pkg::op_ld);
   assign is_st = ex_valid && (ex_op == isa_pkg::op_st);

   // Pipe always wins arbitration, so the request lasts one cycle
   assign pipe_bus.req   = is_ld || is_st;
   assign pipe_bus.we    = is_st;
   assign pipe_bus.addr  = ex_result[dmem_pkg::dmem_addr_width-1:0];
   assign pipe_bus.wdata = ex_store_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_valid <= 1'b0;
         wb_valid   <= 1'b0;
      end else begin
         pend_valid <= is_ld && pipe_bus.gnt;
         wb_valid   <= pend_valid || (ex_writes && !is_ld);
      end
   end

   always_ff @(posedge clk) begin
      pend_dr <= ex_dr;
      if (pend_valid) begin
         wb_dr   <= pend_dr;
         wb_data <= pipe_bus.rdata;
      end else begin
         wb_dr   <= ex_dr;
         wb_data <= ex_result;
      end
   end

   // Load waiting for data, or a result being written this cycle
   assign me_writes  = pend_valid || wb_valid;
   assign me_busy_dr = pend_valid ? pend_dr : wb_dr;

endmodule

`default_nettype wire

//--- verilog/dmem_arbiter.sv
`default_nettype none

module dmem_arbiter (
   input  logic                           clk,
   input  logic                           arst_n,
   dmem_if.arbiter                        pipe_bus,
   input  logic                           host_rd_req,
   input  dmem_pkg::dmem_addr_t           host_rd_addr,
   output logic                           host_rd_valid,
   output logic [isa_pkg::data_width-1:0] host_rd_data
);

   dmem_if host_bus ();

   logic                           host_pend;
   dmem_pkg::dmem_addr_t           host_addr_q;
   dmem_pkg::requester_e           sel;
   dmem_pkg::requester_e           rd_owner_q;
   logic                           acc_gnt;
   logic                           acc_we;
   dmem_pkg::dmem_addr_t           acc_addr;
   logic [isa_pkg::data_width-1:0] acc_wdata;
   logic                           rd_valid_q;
   logic [isa_pkg::data_width-1:0] rd_data_q;
   logic [isa_pkg::data_width-1:0] mem_q [dmem_pkg::dmem_words];

   // Host side holds its read until granted
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         host_pend <= 1'b0;
      end else if (host_rd_req) begin
         host_pend <= 1'b1;
      end else if (host_bus.gnt) begin
         host_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (host_rd_req) begin
         host_addr_q <= host_rd_addr;
      end
   end

   assign host_bus.req   = host_pend;
   assign host_bus.we    = 1'b0;
   assign host_bus.addr  = host_addr_q;
   assign host_bus.wdata = '0;

   // Fixed priority
   assign pipe_bus.gnt = pipe_bus.req;
   assign host_bus.gnt = host_bus.req && !pipe_bus.req;
   assign sel          = pipe_bus.req ? dmem_pkg::req_pipe : dmem_pkg::req_host;

   assign acc_gnt   = pipe_bus.gnt || host_bus.gnt;
   assign acc_we    = (sel == dmem_pkg::req_pipe) ? pipe_bus.we    : host_bus.we;
   assign acc_addr  = (sel == dmem_pkg::req_pipe) ? pipe_bus.addr  : host_bus.addr;
   assign acc_wdata = (sel == dmem_pkg::req_pipe) ? pipe_bus.wdata : host_bus.wdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < dmem_pkg::dmem_words; i++) begin
            mem_q[i] <= '0;
         end
      end else if (acc_gnt && acc_we) begin
         mem_q[acc_addr] <= acc_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (acc_gnt && !acc_we) begin
         rd_data_q <= mem_q[acc_addr];
      end
   end

   // Remember who owns the read data of next cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid_q <= 1'b0;
         rd_owner_q <= dmem_pkg::req_pipe;
      end else begin
         rd_valid_q <= acc_gnt && !acc_we;
         rd_owner_q <= sel;
      end
   end

   assign pipe_bus.rdata = rd_data_q;
   assign host_bus.rdata = rd_data_q;

   assign host_rd_valid = rd_valid_q && (rd_owner_q == dmem_pkg::req_host);
   assign host_rd_data  = host_bus.rdata;

endmodule

`default_nettype wire

//--- verilog/mini_pipe_top.sv
`default_nettype none

module mini_pipe_top (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           instr_valid,
   input  logic [31:0]                    instr_word,
   output logic                           instr_credit,
   input  logic                           host_rd_req,
   input  dmem_pkg::dmem_addr_t           host_rd_addr,
   output logic                           host_rd_valid,
   output logic [isa_pkg::data_width-1:0] host_rd_data,
   output logic                           wb_valid,
   output isa_pkg::gpr_id_t               wb_dr,
   output logic [isa_pkg::data_width-1:0] wb_data
);

   isa_pkg::instr_u                queue_head;
   logic                           head_valid;
   logic                           pop;
   isa_pkg::gpr_id_t               rd_addr_a;
   isa_pkg::gpr_id_t               rd_addr_b;
   logic [isa_pkg::data_width-1:0] rd_data_a;
   logic [isa_pkg::data_width-1:0] rd_data_b;

   logic                           de_valid;
   isa_pkg::opcode_e               de_op;
   isa_pkg::gpr_id_t               de_dr;
   logic [isa_pkg::data_width-1:0] de_a;
   logic [isa_pkg::data_width-1:0] de_b;
   logic [15:0]                    de_disp;

   logic                           ex_valid;
   isa_pkg::opcode_e               ex_op;
   isa_pkg::gpr_id_t               ex_dr;
   logic [isa_pkg::data_width-1:0] ex_result;
   logic [isa_pkg::data_width-1:0] ex_store_data;
   logic                           ex_writes;

   isa_pkg::gpr_id_t               me_busy_dr;
   logic                           me_writes;

   dmem_if pipe_bus ();

   instr_queue u_instr_queue (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (instr_valid),
      .push_word  (instr_word),
      .pop        (pop),
      .head       (queue_head),
      .head_valid (head_valid),
      .credit     (instr_credit)
   );

   // Write port is fed straight from writeback
   register_file u_register_file (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (wb_valid),
      .wr_addr   (wb_dr),
      .wr_data   (wb_data)
   );

   decode_stage u_decode_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .head       (queue_head),
      .head_valid (head_valid),
      .pop        (pop),
      .rd_addr_a  (rd_addr_a),
      .rd_addr_b  (rd_addr_b),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .ex_busy_dr (ex_dr),
      .ex_writes  (ex_writes),
      .me_busy_dr (me_busy_dr),
      .me_writes  (me_writes),
      .de_valid   (de_valid),
      .de_op      (de_op),
      .de_dr      (de_dr),
      .de_a       (de_a),
      .de_b       (de_b),
      .de_disp    (de_disp)
   );

   execute_stage u_execute_stage (
      .clk           (clk),
      .arst_n        (arst_n),
      .de_valid      (de_valid),
      .de_op         (de_op),
      .de_dr         (de_dr),
      .de_a          (de_a),
      .de_b          (de_b),
      .de_disp       (de_disp),
      .ex_valid      (ex_valid),
      .ex_op         (ex_op),
      .ex_dr         (ex_dr),
      .ex_result     (ex_result),
      .ex_store_data (ex_store_data),
      .ex_writes     (ex_writes)
   );

   memory_stage u_memory_stage (
      .clk           (clk),
      .arst_n        (arst_n),
      .ex_valid      (ex_valid),
      .ex_op         (ex_op),
      .ex_dr         (ex_dr),
      .ex_result     (ex_result),
      .ex_store_data (ex_store_data),
      .ex_writes     (ex_writes),
      .pipe_bus      (pipe_bus.requester),
      .me_busy_dr    (me_busy_dr),
      .me_writes     (me_writes),
      .wb_valid      (wb_valid),
      .wb_dr         (wb_dr),
      .wb_data       (wb_data)
   );

   dmem_arbiter u_dmem_arbiter (
      .clk           (clk),
      .arst_n        (arst_n),
      .pipe_bus      (pipe_bus.arbiter),
      .host_rd_req   (host_rd_req),
      .host_rd_addr  (host_rd_addr),
      .host_rd_valid (host_rd_valid),
      .host_rd_data  (host_rd_data)
   );

endmodule

`default_nettype wire

//--- tb/tb_mini_pipe.sv
`default_nettype none

module tb_mini_pipe;

   logic                           clk = 1'b0;
   logic                           arst_n;
   logic                           instr_valid;
   logic [31:0]                    instr_word;
   logic                           instr_credit;
   logic                           host_rd_req;
   dmem_pkg::dmem_addr_t           host_rd_addr;
   logic                           host_rd_valid;
   logic [isa_pkg::data_width-1:0] host_rd_data;
   logic                           wb_valid;
   isa_pkg::gpr_id_t               wb_dr;
   logic [isa_pkg::data_width-1:0] wb_data;

   // Program rows and the writebacks they should produce in order
   logic [31:0]      prog_word [$];
   isa_pkg::gpr_id_t exp_wb_dr [$];
   logic [31:0]      exp_wb_data [$];
   logic [5:0]       host_addr [$];
   logic [31:0]      host_exp [$];

   int          errors = 0;
   int          checks = 0;
   int          wb_count = 0;
   int          credit_pulses = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   logic [31:0] lcg_state = 32'ha5d7a5ff;

   mini_pipe_top dut_i (
      .clk           (clk),
      .arst_n        (arst_n),
      .instr_valid   (instr_valid),
      .instr_word    (instr_word),
      .instr_credit  (instr_credit),
      .host_rd_req   (host_rd_req),
      .host_rd_addr  (host_rd_addr),
      .host_rd_valid (host_rd_valid),
      .host_rd_data  (host_rd_data),
      .wb_valid      (wb_valid),
      .wb_dr         (wb_dr),
      .wb_data       (wb_data)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] encode_reg_form(input isa_pkg::opcode_e op, input int dr,
                                                   input int sr1, input int sr2);
      isa_pkg::instr_u w;
      w           = '0;
      w.rr.opcode = op;
      w.rr.dr     = dr[2:0];
      w.rr.sr1    = sr1[2:0];
      w.rr.sr2    = sr2[2:0];
      return w;
   endfunction

   function automatic logic [31:0] encode_mem_form(input isa_pkg::opcode_e op, input int dr,
                                                   input int base, input int disp);
      isa_pkg::instr_u w;
      w            = '0;
      w.mem.opcode = op;
      w.mem.dr     = dr[2:0];
      w.mem.base   = base[2:0];
      w.mem.disp   = disp[15:0];
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic add_write_row(input logic [31:0] word, input int dr, input logic [31:0] value);
      prog_word.push_back(word);
      exp_wb_dr.push_back(dr[2:0]);
      exp_wb_data.push_back(value);
   endtask

   task automatic add_store_row(input logic [31:0] word);
      prog_word.push_back(word);
   endtask

   task automatic build_tables();
      // ALU ops on two independent sources
      add_write_row(encode_mem_form(isa_pkg::op_movi, 1, 0, 100), 1, 32'h0000_0064);
      add_write_row(encode_mem_form(isa_pkg::op_movi, 2, 0, -7), 2, 32'hffff_fff9);
      add_write_row(encode_reg_form(isa_pkg::op_add, 3, 1, 2), 3, 32'h0000_005d);
      add_write_row(encode_reg_form(isa_pkg::op_sub, 4, 2, 1), 4, 32'hffff_ff95);
      add_write_row(encode_reg_form(isa_pkg::op_and, 5, 1, 2), 5, 32'h0000_0060);
      add_write_row(encode_reg_form(isa_pkg::op_xor, 6, 1, 2), 6, 32'hffff_ff9d);
      // Back-to-back dependent chain where the add wraps past 2^32
      add_write_row(encode_mem_form(isa_pkg::op_movi, 7, 0, -1), 7, 32'hffff_ffff);
      add_write_row(encode_reg_form(isa_pkg::op_add, 7, 7, 1), 7, 32'h0000_0063);
      add_write_row(encode_reg_form(isa_pkg::op_add, 3, 3, 3), 3, 32'h0000_00ba);
      add_write_row(encode_reg_form(isa_pkg::op_sub, 4, 3, 7), 4, 32'h0000_0057);
      add_write_row(encode_reg_form(isa_pkg::op_xor, 5, 4, 3), 5, 32'h0000_00ed);
      // Stores at base minus displacement and loads back
      add_write_row(encode_mem_form(isa_pkg::op_movi, 1, 0, 20), 1, 32'h0000_0014);
      add_store_row(encode_mem_form(isa_pkg::op_st, 5, 1, -4));
      add_store_row(encode_mem_form(isa_pkg::op_st, 6, 1, -1));
      // Address 0x63 keeps only its low six bits
      add_store_row(encode_mem_form(isa_pkg::op_st, 4, 7, 0));
      add_write_row(encode_mem_form(isa_pkg::op_ld, 2, 1, -4), 2, 32'h0000_00ed);
      add_write_row(encode_mem_form(isa_pkg::op_ld, 0, 1, -1), 0, 32'hffff_ff9d);
      add_write_row(encode_reg_form(isa_pkg::op_add, 3, 2, 0), 3, 32'h0000_008a);
      add_write_row(encode_reg_form(isa_pkg::op_sub, 6, 0, 2), 6, 32'hffff_feb0);

      host_addr = '{6'd16, 6'd19, 6'd35, 6'd0, 6'd63, 6'd20};
      host_exp  = '{32'h0000_00ed, 32'hffff_ff9d, 32'h0000_0057, 32'h0, 32'h0, 32'h0};
   endtask

   // Producer side of the credit protocol with random idle gaps
   task automatic send_program();
      int          credits;
      int          row;
      int          gap;
      logic [31:0] rnd;
      credits = isa_pkg::instr_queue_depth;
      row     = 0;
      gap     = 0;
      while (row < prog_word.size()) begin
         @(negedge clk);
         if (instr_credit) begin
            credits++;
         end
         if (credits > isa_pkg::instr_queue_depth) begin
            errors++;
            $display("Credit returned with no word outstanding, before row %0d", row);
         end
         instr_valid = 1'b0;
         if (gap > 0) begin
            gap--;
         end else if (credits > 0) begin
            instr_valid = 1'b1;
            instr_word  = prog_word[row];
            credits--;
            row++;
            rnd = lcg_next();
            gap = int'(rnd[17:16]);
         end
      end
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   task automatic host_read(input logic [5:0] addr, input logic [31:0] exp);
      int lat;
      @(negedge clk);
      host_rd_req  = 1'b1;
      host_rd_addr = addr;
      lat          = 0;
      do begin
         @(negedge clk);
         host_rd_req = 1'b0;
         lat++;
      end while (!host_rd_valid);
      if (lat < 2) begin
         errors++;
         $display("Host read of address 0x%02h answered after only %0d cycle", addr, lat);
      end
      check_value("host_rd_data", host_rd_data, exp);
   endtask

   // Writeback and credit monitor sampled mid-cycle
   always @(negedge clk) begin
      if (instr_credit) begin
         credit_pulses++;
      end
      if (wb_valid) begin
         if (wb_count < exp_wb_data.size()) begin
            check_value("wb_dr", {29'd0, wb_dr}, {29'd0, exp_wb_dr[wb_count]});
            check_value("wb_data", wb_data, exp_wb_data[wb_count]);
         end else begin
            errors++;
            $display("Unexpected writeback to r%0d after the last expected one", wb_dr);
         end
         wb_count++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT did not finish", cycle_count);
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      arst_n       = 1'b0;
      instr_valid  = 1'b0;
      instr_word   = '0;
      host_rd_req  = 1'b0;
      host_rd_addr = '0;
      build_tables();
      cycle_limit = (prog_word.size() + host_addr.size()) * 10 + 10;

      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      send_program();
      while ((wb_count < exp_wb_data.size()) || (credit_pulses < prog_word.size())) begin
         @(negedge clk);
      end
      // Let any stray writeback or credit show up
      repeat (4) @(negedge clk);
      check_value("wb_count", wb_count, exp_wb_data.size());
      check_value("credit_pulses", credit_pulses, prog_word.size());

      for (int i = 0; i < host_addr.size(); i++) begin
         host_read(host_addr[i], host_exp[i]);
      end

      $display("Checks: %0d, errors: %0d, writebacks: %0d, credits: %0d",
               checks, errors, wb_count, credit_pulses);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mini_pipe.f
verilog/isa_pkg.sv
verilog/dmem_pkg.sv
verilog/dmem_if.sv
verilog/instr_queue.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/dmem_arbiter.sv
verilog/mini_pipe_top.sv
tb/tb_mini_pipe.sv

//--- Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_mini_pipe
RTL_TOP    := mini_pipe_top
FILELIST   := mini_pipe.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
